//--- Makefile
# Verilator build for the load/store-multiple unit.

VERILATOR ?= verilator
TB_TOP    ?= tb_lsm_unit
RTL_TOP   ?= lsm_unit
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
SIM_FLAGS ?= -Wno-fatal

RTL_SRCS  := lsm_pkg.sv lsm_manager.sv lsm_sequencer.sv lsm_address_gen.sv lsm_unit.sv
ALL_SRCS  := $(shell cat $(FLIST))
SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FLIST)

$(SIM_BIN): $(ALL_SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- lsm_address_gen.sv
`timescale 1ns/1ns

module lsm_address_gen import lsm_pkg::*; (
	input  logic              CLK,				// System clock.
	input  logic              arst_n,				// Asynchronous reset, active low.
	input  logic              init,				// Start accepted.
	input  logic              xfer_valid,			// A transfer goes out this cycle.
	input  logic [WORD_W-1:0] ir,					// Instruction word, stable during the scan.
	input  logic [WORD_W-1:0] base_addr,			// Base register value, sampled at init.
	output logic [WORD_W-1:0] xfer_addr,			// Address of the current transfer.
	output logic [WORD_W-1:0] wb_addr				// Updated base register value.
);

	logic                 pre_index;				// P flag.
	logic                 walk_down;				// U flag selects decreasing addresses.
	logic [WORD_W-1:0]    base_q;					// Base captured at init.
	logic [WORD_W-1:0]    ptr_q;					// Running transfer address.
	logic [WORD_W-1:0]    first_addr;				// Address of the first transfer.
	logic [WORD_W-1:0]    wb_offset;				// Bytes covered by the whole block.
	logic [LSM_IDX_W:0]   xfer_cnt;				// Transfers issued, 0 to 16.

	assign pre_index = ir[IR_P_BIT];
	assign walk_down = ir[IR_U_BIT];

	// Pre-index moves one word before the first access.
	always_comb begin
		if (!pre_index) begin
			first_addr = base_addr;					// Post-index starts at the base.
		end else if (walk_down) begin
			first_addr = base_addr - WORD_W'(WORD_BYTES);
		end else begin
			first_addr = base_addr + WORD_W'(WORD_BYTES);
		end
	end

	// Base capture and running pointer.
	always_ff @(posedge CLK) begin
		if (init) begin
			base_q <= base_addr;
			ptr_q  <= first_addr;
		end else if (xfer_valid) begin
			if (walk_down) begin
				ptr_q <= ptr_q - WORD_W'(WORD_BYTES);	// Next lower word.
			end else begin
				ptr_q <= ptr_q + WORD_W'(WORD_BYTES);	// Next higher word.
			end
		end
	end

	// Transfer count.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			xfer_cnt <= '0;
		end else if (init) begin
			xfer_cnt <= '0;							// New instruction.
		end else if (xfer_valid) begin
			xfer_cnt <= xfer_cnt + 1'b1;			// One more word moved.
		end
	end

	assign xfer_addr = ptr_q;						// Already positioned for this cycle.

	// Writeback skips the whole block whatever P is.
	assign wb_offset = WORD_W'(xfer_cnt) * WORD_W'(WORD_BYTES);
	assign wb_addr   = walk_down ? (base_q - wb_offset) : (base_q + wb_offset);

endmodule

//--- lsm_manager.sv
`timescale 1ns/1ns

module lsm_manager import lsm_pkg::*; (
	input  logic                 CLK,				// System clock.
	input  logic                 arst_n,			// Asynchronous reset, active low.
	input  logic                 lsm_load,			// Copy the list and preset the counter.
	input  logic                 lsm_step,			// Advance one register position.
	input  logic [WORD_W-1:0]    ir,				// Instruction word, stable during the scan.
	output logic                 cur_bit,			// List bit of the register under scan.
	output logic [LSM_IDX_W-1:0] lsm_counter,		// Index of the register under scan.
	output logic                 lsm_end			// Counter sits on the last index.
);

	logic [LSM_REGS-1:0]  list_q;					// Working copy of the register list.
	logic                 scan_down;				// U flag, descending scan.
	logic [LSM_IDX_W-1:0] first_idx;				// Index the scan begins at.
	logic [LSM_IDX_W-1:0] last_idx;				// Index the scan stops at.

	assign scan_down = ir[IR_U_BIT];				// Direction comes straight from the instruction.

	// Descending scans walk 15 to 0, ascending 0 to 15.
	assign first_idx = scan_down ? LSM_IDX_W'(LSM_REGS - 1) : '0;
	assign last_idx  = scan_down ? '0 : LSM_IDX_W'(LSM_REGS - 1);

	// The register being looked at always sits at the leading end of the shifter.
	assign cur_bit = scan_down ? list_q[LSM_REGS-1] : list_q[0];

	assign lsm_end = (lsm_counter == last_idx);		// Terminal index reached.

	// List shifter, reloaded for every instruction.
	always_ff @(posedge CLK) begin
		if (lsm_load) begin
			list_q <= ir[LIST_MSB:LIST_LSB];		// Take the list field.
		end else if (lsm_step) begin
			if (scan_down) begin
				list_q <= list_q << 1;				// Bring the next lower register to the top.
			end else begin
				list_q <= list_q >> 1;				// Bring the next higher register to bit 0.
			end
		end
	end

	// Register index counter.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			lsm_counter <= '0;
		end else if (lsm_load) begin
			lsm_counter <= first_idx;				// Preset by direction.
		end else if (lsm_step && !lsm_end) begin
			if (scan_down) begin
				lsm_counter <= lsm_counter - 1'b1;	// Walk downward.
			end else begin
				lsm_counter <= lsm_counter + 1'b1;	// Walk upward.
			end
		end
		// Holds at the last index so xfer_reg stays meaningful in the final cycle.
	end

endmodule

//--- lsm_pkg.sv
package lsm_pkg;

	// Register list geometry.
	localparam int LSM_REGS   = 16;					// Registers named in one list.
	localparam int LSM_IDX_W  = 4;					// Bits needed for a register index.

	// Datapath words.
	localparam int WORD_W     = 32;					// Instruction, address and data width.
	localparam int WORD_BYTES = 4;					// Address step between transfers.

	// Control flags of the block transfer instruction.
	localparam int IR_P_BIT   = 24;					// Pre-index when set, post-index when clear.
	localparam int IR_U_BIT   = 23;					// Set scans 15 down to 0 and walks addresses down.
	localparam int IR_W_BIT   = 21;					// Base writeback request.
	localparam int IR_L_BIT   = 20;					// Load when set, store when clear.

	// Register list field.
	localparam int LIST_LSB   = 0;					// Bit of register 0.
	localparam int LIST_MSB   = 15;					// Bit of register 15.

endpackage

//--- lsm_sequencer.sv
`timescale 1ns/1ns

module lsm_sequencer import lsm_pkg::*; (
	input  logic CLK,								// System clock.
	input  logic arst_n,							// Asynchronous reset, active low.
	input  logic start,								// One-cycle start request.
	input  logic cur_bit,							// List bit of the register under scan.
	input  logic lsm_end,							// Manager at its last index.
	output logic busy,								// Unit occupied.
	output logic lsm_load,							// Load the manager and address generator.
	output logic lsm_step,							// Step the manager.
	output logic xfer_valid,						// Transfer strobe.
	output logic done								// End of instruction pulse.
);

	// Three phases of one block transfer.
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,							// Waiting for a start.
		ST_SCAN   = 2'd1,							// Walking the sixteen list positions.
		ST_FINISH = 2'd2							// Reporting done and writeback.
	} seq_state_t;

	seq_state_t state_q;							// Current state.
	seq_state_t state_d;							// Next state.
	logic       accept;								// Start taken this cycle.
	logic       scan_last;							// Final scan position being examined.

	// A start is only honoured from idle, so a request mid-scan is dropped.
	assign accept = start && (state_q == ST_IDLE);

	// The manager steps every scan cycle, whether or not the bit is set.
	assign lsm_step = (state_q == ST_SCAN);

	// Sixteenth position, manager already parked on the last index.
	assign scan_last = lsm_step && lsm_end;

	assign lsm_load   = accept;						// Same edge for manager and address generator.
	assign xfer_valid = lsm_step && cur_bit;		// One strobe per set list bit.
	assign done       = (state_q == ST_FINISH);		// Single cycle after the scan.
	assign busy       = (state_q != ST_IDLE);		// Cycles 1 through 17.

	// Next-state logic.
	always_comb begin
		state_d = state_q;							// Hold by default.
		unique case (state_q)
			ST_IDLE: begin
				if (accept) begin
					state_d = ST_SCAN;				// List loaded at this edge.
				end
			end
			ST_SCAN: begin
				if (scan_last) begin
					state_d = ST_FINISH;			// Fixed length, no early exit on empty lists.
				end
			end
			ST_FINISH: begin
				state_d = ST_IDLE;					// Done lasts one cycle.
			end
			default: begin
				state_d = ST_IDLE;					// Recover from an unused code.
			end
		endcase
	end

	// State register.
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

//--- lsm_unit.sv
`timescale 1ns/1ns

module lsm_unit import lsm_pkg::*; (
	input  logic                 CLK,				// System clock.
	input  logic                 arst_n,			// Asynchronous reset, active low.
	input  logic                 start,			// One-cycle start pulse.
	input  logic [WORD_W-1:0]    ir,				// Instruction word, held until done.
	input  logic [WORD_W-1:0]    base_addr,		// Base register value.
	output logic                 busy,				// Unit occupied.
	output logic                 xfer_valid,		// Transfer strobe.
	output logic [LSM_IDX_W-1:0] xfer_reg,			// Register of the transfer.
	output logic [WORD_W-1:0]    xfer_addr,		// Memory address of the transfer.
	output logic                 xfer_load,		// Load when high, store when low.
	output logic                 done,				// End of instruction.
	output logic                 wb_en,			// Base writeback wanted.
	output logic [WORD_W-1:0]    wb_addr			// New base value.
);

	logic                 lsm_load;				// Start accepted.
	logic                 lsm_step;				// Manager advance.
	logic                 cur_bit;				// Current list bit.
	logic [LSM_IDX_W-1:0] lsm_counter;			// Current register index.
	logic                 lsm_end;				// Scan on its last position.

	// Control FSM.
	lsm_sequencer u_seq (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.start      (start),
		.cur_bit    (cur_bit),
		.lsm_end    (lsm_end),
		.busy       (busy),
		.lsm_load   (lsm_load),
		.lsm_step   (lsm_step),
		.xfer_valid (xfer_valid),
		.done       (done)
	);

	// Register list scanner.
	lsm_manager u_mgr (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.lsm_load    (lsm_load),
		.lsm_step    (lsm_step),
		.ir          (ir),
		.cur_bit     (cur_bit),
		.lsm_counter (lsm_counter),
		.lsm_end     (lsm_end)
	);

	// Address and writeback arithmetic.
	lsm_address_gen u_agen (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.init       (lsm_load),
		.xfer_valid (xfer_valid),
		.ir         (ir),
		.base_addr  (base_addr),
		.xfer_addr  (xfer_addr),
		.wb_addr    (wb_addr)
	);

	assign xfer_reg  = lsm_counter;				// Counter names the register.
	assign xfer_load = ir[IR_L_BIT];				// Direction for every transfer.
	assign wb_en     = ir[IR_W_BIT];				// Meaningful with done.

endmodule

//--- tb_lsm_unit.sv
`timescale 1ns/1ns

module tb_lsm_unit import lsm_pkg::*; ();

	localparam int          SEED           = 32'h4daf_82f8;	// Fixed seed for the random lists.
	localparam int          RESET_CYCLES   = 8;			// Reset held this long.
	localparam int          DONE_CYCLE     = 17;		// Start to done for any list.
	localparam int          MAX_WAIT       = DONE_CYCLE + 3;	// Give up on done after this.
	localparam int          RUNS           = 19;		// Block transfers over all tests.
	localparam int          TIMEOUT_CYCLES = 600;		// RUNS x 20 plus reset and margin.

	logic                 CLK;
	logic                 arst_n;
	logic                 start;
	logic [WORD_W-1:0]    ir;
	logic [WORD_W-1:0]    base_addr;
	logic                 busy;
	logic                 xfer_valid;
	logic [LSM_IDX_W-1:0] xfer_reg;
	logic [WORD_W-1:0]    xfer_addr;
	logic                 xfer_load;
	logic                 done;
	logic                 wb_en;
	logic [WORD_W-1:0]    wb_addr;

	int errors      = 0;							// Failed checks.
	int checks      = 0;							// All checks made.
	int cycle_count = 0;							// Clock edges since time zero.

	// Reference model output for the block under test.
	logic [LSM_IDX_W-1:0] exp_reg_q[$];				// Registers in scan order.
	logic [WORD_W-1:0]    exp_addr_q[$];			// Matching addresses.
	logic [WORD_W-1:0]    exp_wb;					// Expected new base.

	lsm_unit uut (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.start      (start),
		.ir         (ir),
		.base_addr  (base_addr),
		.busy       (busy),
		.xfer_valid (xfer_valid),
		.xfer_reg   (xfer_reg),
		.xfer_addr  (xfer_addr),
		.xfer_load  (xfer_load),
		.done       (done),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;						// 10 ns period.
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
	end

	// Watchdog for a DUT that never finishes.
	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic check_reg(input string name, input logic [LSM_IDX_W-1:0] got,
							 input logic [LSM_IDX_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_word(input string name, input logic [WORD_W-1:0] got,
							  input logic [WORD_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Failure with no single wrong value behind it.
	task automatic report_problem(input string what);
		checks++;
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// Block transfer word with condition AL.
	function automatic logic [WORD_W-1:0] make_ir(input logic p, input logic u, input logic w,
												   input logic l, input logic [LSM_REGS-1:0] list);
		logic [WORD_W-1:0] v;
		v = 32'hE800_0000;
		v[IR_P_BIT] = p;
		v[IR_U_BIT] = u;
		v[IR_W_BIT] = w;
		v[IR_L_BIT] = l;
		v[LIST_MSB:LIST_LSB] = list;
		return v;
	endfunction

	// Transfer list and writeback straight from the instruction rules.
	task automatic build_expected(input logic [WORD_W-1:0] ir_val,
								  input logic [WORD_W-1:0] base_val);
		logic [WORD_W-1:0]   addr;
		logic [LSM_REGS-1:0] list;
		logic                down;
		int                  k;
		int                  r;
		int                  n;
		exp_reg_q.delete();
		exp_addr_q.delete();
		list = ir_val[LIST_MSB:LIST_LSB];
		down = ir_val[IR_U_BIT];
		if (!ir_val[IR_P_BIT]) begin
			addr = base_val;						// Post-index puts the first word at base.
		end else if (down) begin
			addr = base_val - WORD_W'(WORD_BYTES);
		end else begin
			addr = base_val + WORD_W'(WORD_BYTES);
		end
		n = 0;
		for (k = 0; k < LSM_REGS; k++) begin
			r = down ? (LSM_REGS - 1 - k) : k;		// Scan order.
			if (list[r]) begin
				exp_reg_q.push_back(LSM_IDX_W'(r));
				exp_addr_q.push_back(addr);
				addr = down ? addr - WORD_W'(WORD_BYTES) : addr + WORD_W'(WORD_BYTES);
				n++;
			end
		end
		exp_wb = down ? base_val - WORD_W'(n * WORD_BYTES) : base_val + WORD_W'(n * WORD_BYTES);
	endtask

	// One instruction from start to the cycle after done.
	// A nonzero dup_cycle repeats start in that cycle.
	task automatic run_block(input logic [WORD_W-1:0] ir_val, input logic [WORD_W-1:0] base_val,
							 input int dup_cycle);
		int                   cyc;
		int                   seen;
		int                   exp_count;
		bit                   finished;
		logic [LSM_IDX_W-1:0] e_reg;
		logic [WORD_W-1:0]    e_addr;
		build_expected(ir_val, base_val);
		exp_count = exp_reg_q.size();
		@(posedge CLK);
		#1;
		start     = 1'b1;							// Cycle 0.
		ir        = ir_val;
		base_addr = base_val;
		@(negedge CLK);
		check_bit("busy", busy, 1'b0);				// Still idle when start arrives.
		@(posedge CLK);
		#1;
		start     = 1'b0;
		base_addr = ~base_val;						// Base only counts at start.
		cyc       = 1;
		seen      = 0;
		finished  = 1'b0;
		while (!finished && cyc <= MAX_WAIT) begin
			@(negedge CLK);
			check_bit("busy", busy, 1'b1);
			if (xfer_valid) begin
				seen++;
				if (exp_reg_q.size() == 0) begin
					report_problem($sformatf("extra transfer strobe in cycle %0d", cyc));
				end else begin
					e_reg  = exp_reg_q.pop_front();
					e_addr = exp_addr_q.pop_front();
					check_reg("xfer_reg", xfer_reg, e_reg);
					check_word("xfer_addr", xfer_addr, e_addr);
					check_bit("xfer_load", xfer_load, ir_val[IR_L_BIT]);
				end
			end
			if (done) begin
				finished = 1'b1;
				if (cyc != DONE_CYCLE) begin
					report_problem($sformatf("done came in cycle %0d instead of %0d",
											 cyc, DONE_CYCLE));
				end
				if (seen != exp_count) begin
					report_problem($sformatf("saw %0d transfer strobes, expected %0d",
											 seen, exp_count));
				end
				check_bit("wb_en", wb_en, ir_val[IR_W_BIT]);
				check_word("wb_addr", wb_addr, exp_wb);
			end
			@(posedge CLK);
			#1;
			cyc++;
			start = (cyc == dup_cycle);				// Request while busy.
		end
		start     = 1'b0;
		base_addr = base_val;
		if (!finished) begin
			report_problem($sformatf("no done within %0d cycles of start", MAX_WAIT));
		end
		@(negedge CLK);
		check_bit("busy", busy, 1'b0);				// Back to idle.
		check_bit("done", done, 1'b0);
	endtask

	// Nothing may come out while idle.
	task automatic watch_quiet(input int n);
		repeat (n) begin
			@(negedge CLK);
			if (done) begin
				report_problem("done pulsed with no instruction in flight");
			end
			if (xfer_valid) begin
				report_problem("transfer strobe with no instruction in flight");
			end
			check_bit("busy", busy, 1'b0);
		end
	endtask

	task automatic check_reset_values();
		@(negedge CLK);
		check_bit("busy", busy, 1'b0);
		check_bit("xfer_valid", xfer_valid, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("wb_en", wb_en, 1'b0);
	endtask

	task automatic test_ascending_load();
		run_block(make_ir(1'b0, 1'b0, 1'b0, 1'b1, 16'h8421), 32'h0000_1000, 0);
	endtask

	task automatic test_descending_store();
		run_block(make_ir(1'b1, 1'b1, 1'b1, 1'b0, 16'h00F0), 32'h0000_2000, 0);
	endtask

	// Empty and full lists in both scan directions.
	task automatic test_empty_full();
		run_block(make_ir(1'b0, 1'b0, 1'b1, 1'b1, 16'h0000), 32'h0000_4000, 0);
		run_block(make_ir(1'b1, 1'b1, 1'b1, 1'b0, 16'h0000), 32'h0000_5000, 0);
		run_block(make_ir(1'b1, 1'b0, 1'b1, 1'b1, 16'hFFFF), 32'h0000_6000, 0);
		run_block(make_ir(1'b0, 1'b1, 1'b0, 1'b0, 16'hFFFF), 32'h0000_7000, 0);
	endtask

	task automatic test_start_while_busy();
		run_block(make_ir(1'b0, 1'b1, 1'b1, 1'b1, 16'h1248), 32'h0000_3000, 6);
		watch_quiet(8);								// A second done would show here.
	endtask

	task automatic test_random_lists();
		logic [WORD_W-1:0] r;
		logic [WORD_W-1:0] base_val;
		repeat (12) begin
			r        = $urandom();
			base_val = $urandom() & 32'hFFFF_FFFC;	// Word aligned.
			run_block(make_ir(r[16], r[17], r[18], r[19], r[15:0]), base_val, 0);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		arst_n    = 1'b0;
		start     = 1'b0;
		ir        = '0;
		base_addr = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		arst_n = 1'b1;
		check_reset_values();
		test_ascending_load();
		test_descending_store();
		test_empty_full();
		test_start_while_busy();
		test_random_lists();
		$display("Summary: %0d errors in %0d checks over %0d runs", errors, checks, RUNS);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- vlog.f
lsm_pkg.sv
lsm_manager.sv
lsm_sequencer.sv
lsm_address_gen.sv
lsm_unit.sv
tb_lsm_unit.sv
